//--- gbCorePatterns.txt
// tag insn imm wbValid wbReg wbData flags, all hex
// wbReg codes B=0 C=1 D=2 E=3 H=4 L=5 A=7
rstLdBA 47 00 1 0 00 B0
rstLdAB 78 00 1 7 00 B0
rstLdAC 79 00 1 7 00 B0
rstLdAD 7A 00 1 7 00 B0
rstLdAE 7B 00 1 7 00 B0
rstLdAH 7C 00 1 7 00 B0
rstLdAL 7D 00 1 7 00 B0
ldImm12 C6 12 1 7 12 00
ldBA 47 00 1 0 12 00
ldImm23 C6 23 1 7 35 00
ldCA 4F 00 1 1 35 00
ldDB 50 00 1 2 12 00
ldEC 59 00 1 3 35 00
ldImm11 C6 11 1 7 46 00
ldHA 67 00 1 4 46 00
ldLH 6C 00 1 5 46 00
addB 80 00 1 7 58 00
addHalf C6 08 1 7 60 20
addZeroC C6 A0 1 7 00 90
addFF C6 FF 1 7 FF 00
addAA 87 00 1 7 FE 30
subB 90 00 1 7 EC 40
subHalf D6 0F 1 7 DD 60
subAA 97 00 1 7 00 C0
subBorrow D6 01 1 7 FF 70
cpB B8 00 0 0 00 40
cpEqual FE FF 0 0 00 C0
cpC B9 00 0 0 00 40
addAll C6 01 1 7 00 B0
cpBorrow FE 01 0 0 00 70
orB B0 00 1 7 12 00
andC A1 00 1 7 10 20
xorA AF 00 1 7 00 80
orImm F6 F0 1 7 F0 00
andZero E6 0F 1 7 00 A0
xorImm EE 5A 1 7 5A 00
xorD AA 00 1 7 48 00
addToFF C6 B7 1 7 FF 00
ldDA 57 00 1 2 FF 00
incWrap 14 00 1 2 00 A0
decWrap 15 00 1 2 FF 60
setCarry C6 02 1 7 01 30
decZero 3D 00 1 7 00 D0
decKeepC 3D 00 1 7 FF 70
incKeepC 1C 00 1 3 36 10
subTo0F D6 F0 1 7 0F 40
incNibble 3C 00 1 7 10 20
decNibble 3D 00 1 7 0F 60
ldBHlm 46 00 0 0 00 60
addHlm 86 00 0 0 00 60
adcB 88 00 0 0 00 60
sbcB 98 00 0 0 00 60
adcImm CE 05 0 0 00 60
incHlm 34 00 0 0 00 60
nop 00 00 0 0 00 60
jp C3 00 0 0 00 60
halt 76 00 0 0 00 60
b2bLdBA 47 00 1 0 0F 60
b2bIncB 04 00 1 0 10 20
b2bAddB 80 00 1 7 1F 00

//--- list.f
+incdir+.
gbCorePkg.sv
gbDecode.sv
gbAlu.sv
gbRegFile.sv
gbCore.sv
gbCoreChecker.sv
gbCoreTb.sv

//--- Bender.yml
package:
  name: gbCore

sources:
  - include_dirs:
      - .
    files:
      - gbCorePkg.sv
      - gbDecode.sv
      - gbAlu.sv
      - gbRegFile.sv
      - gbCore.sv
      - target: test
        files:
          - gbCoreChecker.sv
          - gbCoreTb.sv

//--- gbCoreTb.sv
`timescale 1ns/1ns

module gbCoreTb
  import gbCorePkg::*;
();

  localparam int    ClockPeriod  = 40;
  localparam int    ResetCycles  = 10;
  localparam int    ResetTimeout = 40;  // Cycles
  localparam int    DrainTimeout = 500; // Tokens read from the file
  localparam string PatternFile  = "gbCorePatterns.txt";

  logic         iClock;
  logic         rstN;
  logic         insnValid;
  logic [7:0]   insn;
  logic [7:0]   immData;
  logic         wbValid;
  regIdxT       wbReg;
  logic [7:0]   wbData;
  logic [7:0]   flags;
  logic [127:0] testName;
  logic         expValid;
  logic [2:0]   expReg;
  logic [7:0]   expData;
  logic [7:0]   expFlags;
  int           errorCount;
  int           checkCount;

  gbCore gbCore_i (
    .iClock(iClock), .rstN(rstN), .insnValid(insnValid), .insn(insn),
    .immData(immData), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .flags(flags)
  );

  gbCoreChecker checker_i (
    .iClock(iClock), .rstN(rstN), .checkEn(insnValid), .testName(testName),
    .expValid(expValid), .expReg(expReg), .expData(expData), .expFlags(expFlags),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .flags(flags),
    .errorCount(errorCount), .checkCount(checkCount)
  );

  initial
  begin
    iClock = 1'b0;
    forever #(ClockPeriod / 2) iClock = ~iClock;
  end

  initial
  begin
    rstN = 1'b0;
    repeat (ResetCycles) @(negedge iClock);
    rstN = 1'b1;
  end

  //----------------------------------------------------------------------
  // Pattern playback
  //----------------------------------------------------------------------
  initial
  begin
    int           fd;
    int           code;
    int           waitCount;
    int           tbErrors;
    int           seed;
    bit           done;
    logic [639:0] restOfLine;
    logic [127:0] tag;
    logic [7:0]   vInsn;
    logic [7:0]   vImm;
    logic         vValid;
    logic [2:0]   vReg;
    logic [7:0]   vData;
    logic [7:0]   vFlags;
    insnValid = 1'b0;
    insn      = '0;
    immData   = '0;
    testName  = '0;
    expValid  = 1'b0;
    expReg    = '0;
    expData   = '0;
    expFlags  = '0;
    seed      = 32'h4501;
    tbErrors  = 0;
    done      = 1'b0;
    waitCount = 0;
    while (rstN !== 1'b1 && waitCount < ResetTimeout)
    begin
      @(negedge iClock);
      waitCount++;
    end
    if (rstN !== 1'b1)
    begin
      $display("Reset was not released within %0d cycles", ResetTimeout);
      tbErrors++;
      done = 1'b1;
    end
    fd = $fopen(PatternFile, "r");
    if (fd == 0)
    begin
      $display("Could not open the pattern file %s", PatternFile);
      tbErrors++;
      done = 1'b1;
    end
    @(negedge iClock); // Quiet cycle checks wbValid low
    waitCount = 0;
    while (!done && waitCount < DrainTimeout)
    begin
      waitCount++;
      code = $fscanf(fd, " %s", tag);
      if (code != 1)
        done = 1'b1;
      else if (tag == "//")
        code = $fgets(restOfLine, fd); // Comment line
      else
      begin
        code = $fscanf(fd, " %h %h %h %h %h %h", vInsn, vImm, vValid, vReg, vData, vFlags);
        if (code != 6)
        begin
          $display("Malformed pattern line for test %0s", tag);
          tbErrors++;
          done = 1'b1;
        end
        else
        begin
          insnValid = 1'b1;
          insn      = vInsn;
          immData   = vImm;
          testName  = tag;
          expValid  = vValid;
          expReg    = vReg;
          expData   = vData;
          expFlags  = vFlags;
          @(negedge iClock);
          insnValid = 1'b0;
          repeat ($unsigned($random(seed)) % 3) @(negedge iClock); // 0 to 2 idle cycles
        end
      end
    end
    if (!done)
    begin
      $display("Pattern file did not drain within %0d reads", DrainTimeout);
      tbErrors++;
    end
    repeat (2) @(negedge iClock);
    $display("Checks: %0d  checker errors: %0d  testbench errors: %0d",
             checkCount, errorCount, tbErrors);
    if (errorCount == 0 && tbErrors == 0 && checkCount > 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- gbCoreChecker.sv
`timescale 1ns/1ns

module gbCoreChecker
(
  input  logic         iClock,
  input  logic         rstN,
  input  logic         checkEn,
  input  logic [127:0] testName,
  input  logic         expValid,
  input  logic [2:0]   expReg,
  input  logic [7:0]   expData,
  input  logic [7:0]   expFlags,
  input  logic         wbValid,
  input  logic [2:0]   wbReg,
  input  logic [7:0]   wbData,
  input  logic [7:0]   flags,
  output int           errorCount,
  output int           checkCount
);

  logic         armed;
  logic [127:0] name;
  logic         valid;
  logic [2:0]   reg3;
  logic [7:0]   data;
  logic [7:0]   flagsExp;

  initial
  begin
    errorCount = 0;
    checkCount = 0;
  end

  task automatic reportMismatch(input string field, input logic [7:0] expV,
                                input logic [7:0] actV);
    errorCount++;
    $display("ERROR: %0s %s expected %h actual %h", name, field, expV, actV);
  endtask

  // Expected record taken with the instruction
  always @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      armed <= 1'b0;
    else
    begin
      armed <= checkEn;
      if (checkEn)
      begin
        name     <= testName;
        valid    <= expValid;
        reg3     <= expReg;
        data     <= expData;
        flagsExp <= expFlags;
      end
    end
  end

  //----------------------------------------------------------------------
  // Compare one cycle after issue
  //----------------------------------------------------------------------
  always @(negedge iClock)
  begin
    if (rstN && armed)
    begin
      checkCount++;
      if (wbValid !== valid)
        reportMismatch("wbValid", valid, wbValid);
      if (valid && wbReg !== reg3)
        reportMismatch("wbReg", reg3, wbReg);
      if (valid && wbData !== data)
        reportMismatch("wbData", data, wbData);
      if (flags !== flagsExp)
        reportMismatch("flags", flagsExp, flags);
    end
    else if (rstN && wbValid !== 1'b0)
    begin
      errorCount++;
      $display("wbValid pulsed although no instruction was issued");
    end
  end

endmodule

//--- gbCore.sv
`timescale 1ns/1ns
`include "gbCore_cfg.svh"

module gbCore
  import gbCorePkg::*;
(
  input  logic                  iClock,
  input  logic                  rstN,
  input  logic                  insnValid,
  input  logic [`GB_DATA_W-1:0] insn,
  input  logic [`GB_DATA_W-1:0] immData,
  output logic                  wbValid,
  output regIdxT                wbReg,
  output logic [`GB_DATA_W-1:0] wbData,
  output logic [`GB_DATA_W-1:0] flags
);

  aluOpT                 aluOp;
  regIdxT                srcReg;
  regIdxT                dstReg;
  logic                  useImm;
  logic                  regWe;
  logic                  flagWe;
  logic [`GB_DATA_W-1:0] srcData;
  logic [`GB_DATA_W-1:0] aData;
  logic [`GB_DATA_W-1:0] result;
  logic [`GB_DATA_W-1:0] newFlags;

  // Decoder and ALU both work in the issue cycle
  gbDecode decode_i (
    .insnValid (insnValid),
    .insn      (insn),
    .aluOp     (aluOp),
    .srcReg    (srcReg),
    .dstReg    (dstReg),
    .useImm    (useImm),
    .regWe     (regWe),
    .flagWe    (flagWe)
  );

  gbAlu alu_i (
    .aluOp    (aluOp),
    .aData    (aData),
    .srcData  (srcData),
    .immData  (immData),
    .useImm   (useImm),
    .curFlags (flags),   // Live flag register
    .result   (result),
    .newFlags (newFlags)
  );

  gbRegFile regFile_i (
    .iClock   (iClock),
    .rstN     (rstN),
    .srcReg   (srcReg),
    .dstReg   (dstReg),
    .regWe    (regWe),
    .flagWe   (flagWe),
    .result   (result),
    .newFlags (newFlags),
    .srcData  (srcData),
    .aData    (aData),
    .curFlags (flags),
    .wbValid  (wbValid),
    .wbReg    (wbReg),
    .wbData   (wbData)
  );

endmodule

//--- gbRegFile.sv
`timescale 1ns/1ns
`include "gbCore_cfg.svh"

module gbRegFile
  import gbCorePkg::*;
(
  input  logic                  iClock,
  input  logic                  rstN,
  input  regIdxT                srcReg,
  input  regIdxT                dstReg,
  input  logic                  regWe,
  input  logic                  flagWe,
  input  logic [`GB_DATA_W-1:0] result,
  input  logic [`GB_DATA_W-1:0] newFlags,
  output logic [`GB_DATA_W-1:0] srcData,
  output logic [`GB_DATA_W-1:0] aData,
  output logic [`GB_DATA_W-1:0] curFlags,
  output logic                  wbValid,
  output regIdxT                wbReg,
  output logic [`GB_DATA_W-1:0] wbData
);

  localparam int SlotW = $clog2(`GB_REG_COUNT);

  logic [`GB_DATA_W-1:0] regs [`GB_REG_COUNT];
  logic [`GB_DATA_W-1:0] flagReg;

  // A sits in the slot left free by the (HL) code
  function automatic logic [SlotW-1:0] slotOf(input regIdxT idx);
    return (idx == A) ? SlotW'(HLM) : SlotW'(idx);
  endfunction

  assign srcData  = regs[slotOf(srcReg)];
  assign aData    = regs[slotOf(A)];
  assign curFlags = flagReg;

  //----------------------------------------------------------------------
  // Working registers and flags
  //----------------------------------------------------------------------
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `GB_REG_COUNT; i++)
        regs[i] <= '0;
      flagReg <= `GB_FLAGS_RESET;
    end
    else
    begin
      if (regWe)
        regs[slotOf(dstReg)] <= result;
      if (flagWe)
        flagReg <= newFlags;
    end
  end

  //----------------------------------------------------------------------
  // Write-back report on the edge of the register write
  //----------------------------------------------------------------------
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      wbValid <= 1'b0;
      wbReg   <= B;
      wbData  <= '0;
    end
    else
    begin
      wbValid <= regWe; // One-cycle pulse
      if (regWe)
      begin
        wbReg  <= dstReg;
        wbData <= result;
      end
    end
  end

endmodule

//--- gbAlu.sv
`timescale 1ns/1ns
`include "gbCore_cfg.svh"

module gbAlu
  import gbCorePkg::*;
(
  input  aluOpT                 aluOp,
  input  logic [`GB_DATA_W-1:0] aData,
  input  logic [`GB_DATA_W-1:0] srcData,
  input  logic [`GB_DATA_W-1:0] immData,
  input  logic                  useImm,
  input  logic [`GB_DATA_W-1:0] curFlags,
  output logic [`GB_DATA_W-1:0] result,
  output logic [`GB_DATA_W-1:0] newFlags
);

  logic [`GB_DATA_W-1:0] operand;
  logic [`GB_DATA_W:0]   sumWide;
  logic [4:0]            halfSum;
  logic [`GB_DATA_W-1:0] diff;
  logic                  borrow;
  logic                  halfBorrow;
  logic                  nFlag;
  logic                  hFlag;
  logic                  cFlag;

  assign operand    = useImm ? immData : srcData;
  assign sumWide    = {1'b0, aData} + {1'b0, operand};
  assign halfSum    = {1'b0, aData[3:0]} + {1'b0, operand[3:0]}; // Bit 4 is H
  assign diff       = aData - operand;
  assign borrow     = (aData < operand);
  assign halfBorrow = (aData[3:0] < operand[3:0]);

  always_comb
  begin
    result = operand;
    nFlag  = 1'b0;
    hFlag  = 1'b0;
    cFlag  = 1'b0;
    case (aluOp)
      ADD:
      begin
        result = sumWide[`GB_DATA_W-1:0];
        hFlag  = halfSum[4];
        cFlag  = sumWide[`GB_DATA_W];
      end
      SUB, CP: // CP result only feeds Z
      begin
        result = diff;
        nFlag  = 1'b1;
        hFlag  = halfBorrow;
        cFlag  = borrow;
      end
      AND:
      begin
        result = aData & operand;
        hFlag  = 1'b1;
      end
      XOR: result = aData ^ operand;
      OR:  result = aData | operand;
      INC:
      begin
        result = operand + 1'b1;
        hFlag  = (result[3:0] == 4'h0);
        cFlag  = curFlags[`GB_FLAG_C];
      end
      DEC:
      begin
        result = operand - 1'b1;
        nFlag  = 1'b1;
        hFlag  = (result[3:0] == 4'hF);
        cFlag  = curFlags[`GB_FLAG_C];
      end
      default: ; // PASS and NOP hand the operand through
    endcase
  end

  always_comb
  begin
    newFlags             = '0; // Low nibble stays zero
    newFlags[`GB_FLAG_Z] = (result == '0);
    newFlags[`GB_FLAG_N] = nFlag;
    newFlags[`GB_FLAG_H] = hFlag;
    newFlags[`GB_FLAG_C] = cFlag;
    if (aluOp == PASS || aluOp == NOP)
      newFlags = curFlags;
  end

endmodule

//--- gbDecode.sv
`timescale 1ns/1ns
`include "gbCore_cfg.svh"

module gbDecode
  import gbCorePkg::*;
(
  input  logic                  insnValid,
  input  logic [`GB_DATA_W-1:0] insn,
  output aluOpT                 aluOp,
  output regIdxT                srcReg,
  output regIdxT                dstReg,
  output logic                  useImm,
  output logic                  regWe,
  output logic                  flagWe
);

  logic [1:0] group;
  logic [2:0] fieldHi;
  logic [2:0] fieldLo;
  aluOpT      groupOp;

  // Op select of the 10xxxrrr and 11xxx110 groups
  function automatic aluOpT groupToOp(input logic [2:0] sel);
    case (sel)
      3'b000:  return ADD;
      3'b010:  return SUB;
      3'b100:  return AND;
      3'b101:  return XOR;
      3'b110:  return OR;
      3'b111:  return CP;
      default: return NOP; // ADC, SBC
    endcase
  endfunction

  assign group   = insn[7:6];
  assign fieldHi = insn[5:3];
  assign fieldLo = insn[2:0];
  assign groupOp = groupToOp(fieldHi);

  always_comb
  begin
    aluOp  = NOP;
    srcReg = regIdxT'(fieldLo);
    dstReg = regIdxT'(fieldHi);
    useImm = 1'b0;
    regWe  = 1'b0;
    flagWe = 1'b0;
    if (insnValid)
    begin
      case (group)
        2'b01: // LD r,r'
        begin
          if (fieldHi != HLM && fieldLo != HLM)
          begin
            aluOp = PASS;
            regWe = 1'b1;
          end
        end
        2'b10: // ALU A,r
        begin
          if (groupOp != NOP && fieldLo != HLM)
          begin
            aluOp  = groupOp;
            dstReg = A;
            regWe  = (groupOp != CP);
            flagWe = 1'b1;
          end
        end
        2'b00:
        begin
          // INC r and DEC r work on the destination itself
          if (fieldHi != HLM && (fieldLo == 3'b100 || fieldLo == 3'b101))
          begin
            aluOp  = fieldLo[0] ? DEC : INC;
            srcReg = regIdxT'(fieldHi);
            regWe  = 1'b1;
            flagWe = 1'b1;
          end
        end
        default: // ALU A,n in 11xxx110
        begin
          if (fieldLo == 3'b110 && groupOp != NOP)
          begin
            aluOp  = groupOp;
            useImm = 1'b1;
            dstReg = A;
            regWe  = (groupOp != CP);
            flagWe = 1'b1;
          end
        end
      endcase
    end
  end

endmodule

//--- gbCorePkg.sv
package gbCorePkg;

  // ----------------------------------------------------------------------
  // Register codes as found in opcode bits 5:3 and 2:0
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    B   = 3'd0,
    C   = 3'd1,
    D   = 3'd2,
    E   = 3'd3,
    H   = 3'd4,
    L   = 3'd5,
    HLM = 3'd6, // Memory operand (HL) is unsupported
    A   = 3'd7
  } regIdxT;

  // ----------------------------------------------------------------------
  // ALU operations
  // ----------------------------------------------------------------------
  // First six follow the 10xxx group order without ADC and SBC
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    XOR  = 4'd3,
    OR   = 4'd4,
    CP   = 4'd5,
    INC  = 4'd6,
    DEC  = 4'd7,
    PASS = 4'd8, // LD r,r'
    NOP  = 4'd9
  } aluOpT;

endpackage

//--- gbCore_cfg.svh
`ifndef GB_CORE_CFG_SVH
`define GB_CORE_CFG_SVH

// Datapath width
`define GB_DATA_W 8

// Working registers B C D E H L A
`define GB_REG_COUNT 7

`define GB_FLAGS_RESET 8'hB0

`define GB_FLAG_Z 7
`define GB_FLAG_N 6
`define GB_FLAG_H 5
`define GB_FLAG_C 4

`endif
